//--- include/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// AXI ID space with one busy flag per ID
`define BRIDGE_ID_WIDTH 4
`define BRIDGE_ID_COUNT 16

// Byte address, same on both sides
`define BRIDGE_ADDR_WIDTH 64

// Beat and word widths
`define BRIDGE_AXI_DATA_WIDTH 32
`define BRIDGE_OC_DATA_WIDTH 64

// AXI length field holds beats minus one
`define BRIDGE_LEN_WIDTH 8

// Two beats at most
`define BRIDGE_MAX_LEN 1

`endif

//--- src/axi_pkg.sv
`include "bridge_config.svh"

package axi_pkg;

   // Transaction ID, also used unchanged on the OpenCAPI side
   typedef logic [`BRIDGE_ID_WIDTH-1:0] axi_id_t;

   // Byte address
   typedef logic [`BRIDGE_ADDR_WIDTH-1:0] axi_addr_t;

   // Beats minus one
   typedef logic [`BRIDGE_LEN_WIDTH-1:0] axi_len_t;

   // One AXI data beat
   typedef logic [`BRIDGE_AXI_DATA_WIDTH-1:0] axi_data_t;

   // OKAY, EXOKAY, SLVERR, DECERR
   typedef logic [1:0] axi_resp_t;

endpackage

//--- src/ocx_pkg.sv
`include "bridge_config.svh"

package ocx_pkg;

   // AXI beats per OpenCAPI word
   localparam int OC_BEATS = `BRIDGE_OC_DATA_WIDTH / `BRIDGE_AXI_DATA_WIDTH;

   // One OpenCAPI word, seen whole or as two AXI beats
   // Upper beat sits in bits 63 to 32
   // A one-beat transfer only uses beat 0
   // A two-beat transfer sends beat 1 first
   typedef union packed {
      logic [`BRIDGE_OC_DATA_WIDTH-1:0]  word;
      axi_pkg::axi_data_t [OC_BEATS-1:0] beat;
   } oc_data_t;

endpackage

//--- src/outstanding_id_table.sv
`timescale 1ns/1ps

`include "bridge_config.svh"

module outstanding_id_table (
   input  logic              s0_axi_aclk,
   input  logic              rst_n,
   // Write side
   input  axi_pkg::axi_id_t  wr_query_id,
   output logic              wr_busy,
   input  logic              wr_set,
   input  logic              wr_clear,
   input  axi_pkg::axi_id_t  wr_set_id,
   input  axi_pkg::axi_id_t  wr_clear_id,
   // Read side
   input  axi_pkg::axi_id_t  rd_query_id,
   output logic              rd_busy,
   input  logic              rd_set,
   input  logic              rd_clear,
   input  axi_pkg::axi_id_t  rd_set_id,
   input  axi_pkg::axi_id_t  rd_clear_id,
   input  axi_pkg::axi_len_t rd_set_len,
   input  axi_pkg::axi_id_t  rd_len_id,
   output axi_pkg::axi_len_t rd_len
);
   import axi_pkg::*;

   logic [`BRIDGE_ID_COUNT-1:0] wr_busy_q;
   logic [`BRIDGE_ID_COUNT-1:0] rd_busy_q;
   axi_len_t                    rd_len_q [`BRIDGE_ID_COUNT];

   // Lookups for the channel blocks
   assign wr_busy = wr_busy_q[wr_query_id];
   assign rd_busy = rd_busy_q[rd_query_id];
   assign rd_len  = rd_len_q[rd_len_id];

   // Busy flags, set on command accept and cleared on the last AXI handshake
   always_ff @(posedge s0_axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_busy_q <= '0;
         rd_busy_q <= '0;
      end else begin
         if (wr_clear) begin
            wr_busy_q[wr_clear_id] <= 1'b0;
         end
         if (wr_set) begin
            wr_busy_q[wr_set_id] <= 1'b1;
         end
         if (rd_clear) begin
            rd_busy_q[rd_clear_id] <= 1'b0;
         end
         if (rd_set) begin
            rd_busy_q[rd_set_id] <= 1'b1;
         end
      end
   end

   // Length of each open read, tells the R path how many beats to send
   always_ff @(posedge s0_axi_aclk) begin
      if (rd_set) begin
         rd_len_q[rd_set_id] <= rd_set_len;
      end
   end

endmodule

//--- src/axi_write_channels.sv
`timescale 1ns/1ps

module axi_write_channels (
   input  logic               s0_axi_aclk,
   input  logic               rst_n,
   // AW
   input  axi_pkg::axi_id_t   s0_axi_awid,
   input  axi_pkg::axi_addr_t s0_axi_awaddr,
   input  axi_pkg::axi_len_t  s0_axi_awlen,
   input  logic               s0_axi_awvalid,
   output logic               s0_axi_awready,
   // W
   input  axi_pkg::axi_data_t s0_axi_wdata,
   input  logic               s0_axi_wlast,
   input  logic               s0_axi_wvalid,
   output logic               s0_axi_wready,
   // B
   output axi_pkg::axi_id_t   s0_axi_bid,
   output axi_pkg::axi_resp_t s0_axi_bresp,
   output logic               s0_axi_bvalid,
   input  logic               s0_axi_bready,
   // OpenCAPI write command
   output logic               oc_write_command_valid,
   output axi_pkg::axi_id_t   oc_write_command_id,
   output axi_pkg::axi_addr_t oc_write_command_address,
   output axi_pkg::axi_len_t  oc_write_command_length,
   output ocx_pkg::oc_data_t  oc_write_command_data,
   input  logic               oc_write_command_ready,
   // OpenCAPI write response
   input  logic               oc_trans_bvalid,
   input  axi_pkg::axi_id_t   oc_trans_bid,
   input  axi_pkg::axi_resp_t oc_trans_bresp,
   output logic               oc_trans_bready,
   // Outstanding table
   input  logic               wr_busy,
   output logic               wr_set,
   output axi_pkg::axi_id_t   wr_set_id,
   output logic               wr_clear,
   output axi_pkg::axi_id_t   wr_clear_id
);
   logic idle;
   logic w_hs;
   logic b_load;
   logic beat_q;
   logic half;

   // The three phase flags double as the FSM state, all low means idle
   assign idle   = !s0_axi_awready && !s0_axi_wready && !oc_write_command_valid;
   assign w_hs   = s0_axi_wvalid && s0_axi_wready;
   assign b_load = oc_trans_bvalid && oc_trans_bready;

   // Second beat always lands in half 0
   assign half = oc_write_command_length[0] && !beat_q;

   assign wr_set      = oc_write_command_valid && oc_write_command_ready;
   assign wr_set_id   = oc_write_command_id;
   assign wr_clear    = s0_axi_bvalid && s0_axi_bready;
   assign wr_clear_id = s0_axi_bid;

   // Address and data phases, then the command
   always_ff @(posedge s0_axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         s0_axi_awready         <= 1'b0;
         s0_axi_wready          <= 1'b0;
         oc_write_command_valid <= 1'b0;
         beat_q                 <= 1'b0;
      end else begin
         // One-cycle pulse; awvalid is stable so this is the handshake
         s0_axi_awready <= idle && s0_axi_awvalid && !wr_busy;

         if (s0_axi_awready) begin
            s0_axi_wready <= 1'b1;
         end else if (w_hs && s0_axi_wlast) begin
            s0_axi_wready <= 1'b0;
         end

         if (w_hs && s0_axi_wlast) begin
            oc_write_command_valid <= 1'b1;
         end else if (wr_set) begin
            oc_write_command_valid <= 1'b0;
         end

         if (s0_axi_awready) begin
            beat_q <= 1'b0;
         end else if (w_hs) begin
            beat_q <= 1'b1;
         end
      end
   end

   // Command fields double as the latched AW fields
   always_ff @(posedge s0_axi_aclk) begin
      if (s0_axi_awready) begin
         oc_write_command_id        <= s0_axi_awid;
         oc_write_command_address   <= s0_axi_awaddr;
         oc_write_command_length    <= s0_axi_awlen;
         oc_write_command_data.word <= '0;
      end
      if (w_hs) begin
         oc_write_command_data.beat[half] <= s0_axi_wdata;
      end
   end

   // One-entry response register, OpenCAPI side is held off while it is full
   always_ff @(posedge s0_axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         s0_axi_bvalid   <= 1'b0;
         oc_trans_bready <= 1'b0;
      end else if (b_load) begin
         s0_axi_bvalid   <= 1'b1;
         oc_trans_bready <= 1'b0;
      end else if (!s0_axi_bvalid || s0_axi_bready) begin
         s0_axi_bvalid   <= 1'b0;
         oc_trans_bready <= 1'b1;
      end
   end

   always_ff @(posedge s0_axi_aclk) begin
      if (b_load) begin
         s0_axi_bid   <= oc_trans_bid;
         s0_axi_bresp <= oc_trans_bresp;
      end
   end

endmodule

//--- src/axi_read_channels.sv
`timescale 1ns/1ps

module axi_read_channels (
   input  logic               s0_axi_aclk,
   input  logic               rst_n,
   // AR
   input  axi_pkg::axi_id_t   s0_axi_arid,
   input  axi_pkg::axi_addr_t s0_axi_araddr,
   input  axi_pkg::axi_len_t  s0_axi_arlen,
   input  logic               s0_axi_arvalid,
   output logic               s0_axi_arready,
   // R
   output axi_pkg::axi_id_t   s0_axi_rid,
   output axi_pkg::axi_data_t s0_axi_rdata,
   output axi_pkg::axi_resp_t s0_axi_rresp,
   output logic               s0_axi_rlast,
   output logic               s0_axi_rvalid,
   input  logic               s0_axi_rready,
   // OpenCAPI read command
   output logic               oc_read_command_valid,
   output axi_pkg::axi_id_t   oc_read_command_id,
   output axi_pkg::axi_addr_t oc_read_command_address,
   output axi_pkg::axi_len_t  oc_read_command_length,
   input  logic               oc_read_command_ready,
   // OpenCAPI read data
   input  logic               oc_trans_rvalid,
   input  axi_pkg::axi_id_t   oc_trans_rid,
   input  ocx_pkg::oc_data_t  oc_trans_rdata,
   input  axi_pkg::axi_resp_t oc_trans_rresp,
   output logic               oc_trans_rready,
   // Outstanding table
   input  logic               rd_busy,
   output logic               rd_set,
   output axi_pkg::axi_id_t   rd_set_id,
   output axi_pkg::axi_len_t  rd_set_len,
   output logic               rd_clear,
   output axi_pkg::axi_id_t   rd_clear_id,
   output axi_pkg::axi_id_t   rd_len_id,
   input  axi_pkg::axi_len_t  rd_len
);
   import axi_pkg::*;

   logic      idle;
   logic      r_load;
   logic      r_hs;
   axi_data_t second_beat_q;

   assign idle   = !s0_axi_arready && !oc_read_command_valid;
   assign r_load = oc_trans_rvalid && oc_trans_rready;
   assign r_hs   = s0_axi_rvalid && s0_axi_rready;

   assign rd_set      = oc_read_command_valid && oc_read_command_ready;
   assign rd_set_id   = oc_read_command_id;
   assign rd_set_len  = oc_read_command_length;
   assign rd_clear    = r_hs && s0_axi_rlast;
   assign rd_clear_id = s0_axi_rid;

   // Length lookup for the word arriving now
   assign rd_len_id = oc_trans_rid;

   // AR acceptance and the read command
   always_ff @(posedge s0_axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         s0_axi_arready        <= 1'b0;
         oc_read_command_valid <= 1'b0;
      end else begin
         s0_axi_arready <= idle && s0_axi_arvalid && !rd_busy;

         if (s0_axi_arready) begin
            oc_read_command_valid <= 1'b1;
         end else if (rd_set) begin
            oc_read_command_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge s0_axi_aclk) begin
      if (s0_axi_arready) begin
         oc_read_command_id      <= s0_axi_arid;
         oc_read_command_address <= s0_axi_araddr;
         oc_read_command_length  <= s0_axi_arlen;
      end
   end

   // R beats out of one held word
   // rlast is known at load time from the stored length
   always_ff @(posedge s0_axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         s0_axi_rvalid   <= 1'b0;
         s0_axi_rlast    <= 1'b0;
         oc_trans_rready <= 1'b0;
      end else if (r_load) begin
         s0_axi_rvalid   <= 1'b1;
         s0_axi_rlast    <= (rd_len == '0);
         oc_trans_rready <= 1'b0;
      end else if (r_hs && !s0_axi_rlast) begin
         s0_axi_rlast <= 1'b1;
      end else if (!s0_axi_rvalid || s0_axi_rready) begin
         s0_axi_rvalid   <= 1'b0;
         oc_trans_rready <= 1'b1;
      end
   end

   // Two-beat reads send beat 1 first, one-beat reads only beat 0
   always_ff @(posedge s0_axi_aclk) begin
      if (r_load) begin
         s0_axi_rid    <= oc_trans_rid;
         s0_axi_rresp  <= oc_trans_rresp;
         s0_axi_rdata  <= oc_trans_rdata.beat[rd_len[0]];
         second_beat_q <= oc_trans_rdata.beat[0];
      end else if (r_hs && !s0_axi_rlast) begin
         s0_axi_rdata <= second_beat_q;
      end
   end

endmodule

//--- src/ocx_tlx_axi_bridge.sv
`timescale 1ns/1ps

module ocx_tlx_axi_bridge (
   input  logic               s0_axi_aclk,
   input  logic               rst_n,
   // AXI write
   input  axi_pkg::axi_id_t   s0_axi_awid,
   input  axi_pkg::axi_addr_t s0_axi_awaddr,
   input  axi_pkg::axi_len_t  s0_axi_awlen,
   input  logic               s0_axi_awvalid,
   output logic               s0_axi_awready,
   input  axi_pkg::axi_data_t s0_axi_wdata,
   input  logic               s0_axi_wlast,
   input  logic               s0_axi_wvalid,
   output logic               s0_axi_wready,
   output axi_pkg::axi_id_t   s0_axi_bid,
   output axi_pkg::axi_resp_t s0_axi_bresp,
   output logic               s0_axi_bvalid,
   input  logic               s0_axi_bready,
   // AXI read
   input  axi_pkg::axi_id_t   s0_axi_arid,
   input  axi_pkg::axi_addr_t s0_axi_araddr,
   input  axi_pkg::axi_len_t  s0_axi_arlen,
   input  logic               s0_axi_arvalid,
   output logic               s0_axi_arready,
   output axi_pkg::axi_id_t   s0_axi_rid,
   output axi_pkg::axi_data_t s0_axi_rdata,
   output axi_pkg::axi_resp_t s0_axi_rresp,
   output logic               s0_axi_rlast,
   output logic               s0_axi_rvalid,
   input  logic               s0_axi_rready,
   // OpenCAPI write command and response
   output logic               oc_write_command_valid,
   output axi_pkg::axi_id_t   oc_write_command_id,
   output axi_pkg::axi_addr_t oc_write_command_address,
   output axi_pkg::axi_len_t  oc_write_command_length,
   output ocx_pkg::oc_data_t  oc_write_command_data,
   input  logic               oc_write_command_ready,
   input  logic               oc_trans_bvalid,
   input  axi_pkg::axi_id_t   oc_trans_bid,
   input  axi_pkg::axi_resp_t oc_trans_bresp,
   output logic               oc_trans_bready,
   // OpenCAPI read command and data
   output logic               oc_read_command_valid,
   output axi_pkg::axi_id_t   oc_read_command_id,
   output axi_pkg::axi_addr_t oc_read_command_address,
   output axi_pkg::axi_len_t  oc_read_command_length,
   input  logic               oc_read_command_ready,
   input  logic               oc_trans_rvalid,
   input  axi_pkg::axi_id_t   oc_trans_rid,
   input  ocx_pkg::oc_data_t  oc_trans_rdata,
   input  axi_pkg::axi_resp_t oc_trans_rresp,
   output logic               oc_trans_rready
);
   import axi_pkg::*;

   // Table hookup
   logic     wr_busy;
   logic     wr_set;
   logic     wr_clear;
   axi_id_t  wr_set_id;
   axi_id_t  wr_clear_id;
   logic     rd_busy;
   logic     rd_set;
   logic     rd_clear;
   axi_id_t  rd_set_id;
   axi_id_t  rd_clear_id;
   axi_id_t  rd_len_id;
   axi_len_t rd_set_len;
   axi_len_t rd_len;

   // Busy flags are queried with the IDs waiting on AW and AR
   outstanding_id_table u_id_table (
      .s0_axi_aclk (s0_axi_aclk),
      .rst_n       (rst_n),
      .wr_query_id (s0_axi_awid),
      .wr_busy     (wr_busy),
      .wr_set      (wr_set),
      .wr_clear    (wr_clear),
      .wr_set_id   (wr_set_id),
      .wr_clear_id (wr_clear_id),
      .rd_query_id (s0_axi_arid),
      .rd_busy     (rd_busy),
      .rd_set      (rd_set),
      .rd_clear    (rd_clear),
      .rd_set_id   (rd_set_id),
      .rd_clear_id (rd_clear_id),
      .rd_set_len  (rd_set_len),
      .rd_len_id   (rd_len_id),
      .rd_len      (rd_len)
   );

   // Port names match the top level one to one
   axi_write_channels u_write (.*);

   axi_read_channels u_read (.*);

endmodule

//--- bench/bridge_assertions.sv
`timescale 1ns/1ps

`include "bridge_config.svh"

module bridge_assertions (
   input logic              s0_axi_aclk,
   input logic              rst_n,
   input logic              s0_axi_awvalid,
   input logic              s0_axi_awready,
   input axi_pkg::axi_len_t s0_axi_awlen,
   input logic              s0_axi_arvalid,
   input logic              s0_axi_arready,
   input axi_pkg::axi_len_t s0_axi_arlen,
   input logic              s0_axi_bvalid,
   input logic              s0_axi_bready,
   input logic              s0_axi_rvalid,
   input logic              s0_axi_rready,
   input logic              oc_write_command_valid,
   input logic              oc_write_command_ready,
   input logic              oc_read_command_valid,
   input logic              oc_read_command_ready
);

   // Failed assertions so far
   int fail_count = 0;

   // A valid that is not taken stays up
   property held_until_taken(valid, ready);
      @(posedge s0_axi_aclk) disable iff (!rst_n) valid && !ready |=> valid;
   endproperty

   b_held: assert property (held_until_taken(s0_axi_bvalid, s0_axi_bready))
   else begin
      fail_count++;
      $error("bvalid dropped before bready");
   end
   r_held: assert property (held_until_taken(s0_axi_rvalid, s0_axi_rready))
   else begin
      fail_count++;
      $error("rvalid dropped before rready");
   end
   wcmd_held: assert property (held_until_taken(oc_write_command_valid, oc_write_command_ready))
   else begin
      fail_count++;
      $error("write command valid dropped before ready");
   end
   rcmd_held: assert property (held_until_taken(oc_read_command_valid, oc_read_command_ready))
   else begin
      fail_count++;
      $error("read command valid dropped before ready");
   end

   // Bursts of one or two beats only
   aw_len_ok: assert property (@(posedge s0_axi_aclk) disable iff (!rst_n)
      s0_axi_awvalid && s0_axi_awready |-> s0_axi_awlen <= `BRIDGE_MAX_LEN)
   else begin
      fail_count++;
      $error("AW accepted with a length above two beats");
   end
   ar_len_ok: assert property (@(posedge s0_axi_aclk) disable iff (!rst_n)
      s0_axi_arvalid && s0_axi_arready |-> s0_axi_arlen <= `BRIDGE_MAX_LEN)
   else begin
      fail_count++;
      $error("AR accepted with a length above two beats");
   end

endmodule

bind ocx_tlx_axi_bridge bridge_assertions u_assertions (.*);

//--- bench/bridge_tb.sv
`timescale 1ns/1ps

module bridge_tb;
   import axi_pkg::*;
   import ocx_pkg::*;

   localparam int kind_write = 0;
   localparam int kind_read  = 1;
   localparam int kind_busy  = 2;

   logic      s0_axi_aclk = 1'b0;
   logic      rst_n;
   // AXI write
   axi_id_t   s0_axi_awid;
   axi_addr_t s0_axi_awaddr;
   axi_len_t  s0_axi_awlen;
   logic      s0_axi_awvalid;
   logic      s0_axi_awready;
   axi_data_t s0_axi_wdata;
   logic      s0_axi_wlast;
   logic      s0_axi_wvalid;
   logic      s0_axi_wready;
   axi_id_t   s0_axi_bid;
   axi_resp_t s0_axi_bresp;
   logic      s0_axi_bvalid;
   logic      s0_axi_bready;
   // AXI read
   axi_id_t   s0_axi_arid;
   axi_addr_t s0_axi_araddr;
   axi_len_t  s0_axi_arlen;
   logic      s0_axi_arvalid;
   logic      s0_axi_arready;
   axi_id_t   s0_axi_rid;
   axi_data_t s0_axi_rdata;
   axi_resp_t s0_axi_rresp;
   logic      s0_axi_rlast;
   logic      s0_axi_rvalid;
   logic      s0_axi_rready;
   // OpenCAPI write command and response
   logic      oc_write_command_valid;
   axi_id_t   oc_write_command_id;
   axi_addr_t oc_write_command_address;
   axi_len_t  oc_write_command_length;
   oc_data_t  oc_write_command_data;
   logic      oc_write_command_ready;
   logic      oc_trans_bvalid;
   axi_id_t   oc_trans_bid;
   axi_resp_t oc_trans_bresp;
   logic      oc_trans_bready;
   // OpenCAPI read command and data
   logic      oc_read_command_valid;
   axi_id_t   oc_read_command_id;
   axi_addr_t oc_read_command_address;
   axi_len_t  oc_read_command_length;
   logic      oc_read_command_ready;
   logic      oc_trans_rvalid;
   axi_id_t   oc_trans_rid;
   oc_data_t  oc_trans_rdata;
   axi_resp_t oc_trans_rresp;
   logic      oc_trans_rready;

   // Test table
   int        t_kind[$];
   axi_id_t   t_id[$];
   axi_addr_t t_addr[$];
   axi_len_t  t_len[$];
   axi_data_t t_first[$];
   axi_data_t t_second[$];
   axi_resp_t t_resp[$];
   string     t_name[$];

   integer    seed;
   string     cur_name;
   logic      test_ok;
   int        errors;
   int        passed;
   int        failed;

   ocx_tlx_axi_bridge u_dut (.*);

   always #5 s0_axi_aclk = ~s0_axi_aclk;

   function automatic logic coin();
      logic [31:0] r;
      r = $random(seed);
      return r[0];
   endfunction

   // Expected command word from the packing rule
   function automatic oc_data_t write_word(input axi_len_t len, input axi_data_t first,
                                           input axi_data_t second);
      oc_data_t w;
      w.word = '0;
      if (len == 0) begin
         w.beat[0] = first;
      end else begin
         w.beat[1] = first;
         w.beat[0] = second;
      end
      return w;
   endfunction

   task automatic add_test(input int kind, input axi_id_t id, input axi_addr_t addr,
                           input axi_len_t len, input axi_data_t first,
                           input axi_data_t second, input axi_resp_t resp, input string name);
      t_kind.push_back(kind);
      t_id.push_back(id);
      t_addr.push_back(addr);
      t_len.push_back(len);
      t_first.push_back(first);
      t_second.push_back(second);
      t_resp.push_back(resp);
      t_name.push_back(name);
   endtask

   task automatic report_mismatch(input string what, input string exp, input string act);
      $display("error %s %s: expected %s, actual %s", cur_name, what, exp, act);
      errors++;
      test_ok = 1'b0;
   endtask

   task automatic report_failure(input string msg);
      $display("%s: %s", cur_name, msg);
      errors++;
      test_ok = 1'b0;
   endtask

   task automatic check_oc_data(input string what, input oc_data_t exp, input oc_data_t act);
      if (act !== exp) begin
         report_mismatch(what, $sformatf("%h", exp.word), $sformatf("%h", act.word));
      end
   endtask

   task automatic check_beat(input string what, input axi_data_t exp, input axi_data_t act);
      if (act !== exp) begin
         report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
      end
   endtask

   task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
      if (act !== exp) begin
         report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
      end
   endtask

   task automatic check_id(input string what, input axi_id_t exp, input axi_id_t act);
      if (act !== exp) begin
         report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
      end
   endtask

   task automatic check_addr(input string what, input axi_addr_t exp, input axi_addr_t act);
      if (act !== exp) begin
         report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
      end
   endtask

   task automatic check_len(input string what, input axi_len_t exp, input axi_len_t act);
      if (act !== exp) begin
         report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
      end
   endtask

   task automatic check_last(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
      end
   endtask

   task automatic drive_aw(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
      s0_axi_awid    <= id;
      s0_axi_awaddr  <= addr;
      s0_axi_awlen   <= len;
      s0_axi_awvalid <= 1'b1;
   endtask

   task automatic wait_aw();
      do @(posedge s0_axi_aclk); while (!(s0_axi_awvalid && s0_axi_awready));
      s0_axi_awvalid <= 1'b0;
   endtask

   task automatic send_w(input axi_len_t len, input axi_data_t first, input axi_data_t second);
      s0_axi_wdata  <= first;
      s0_axi_wlast  <= (len == 0);
      s0_axi_wvalid <= 1'b1;
      do @(posedge s0_axi_aclk); while (!(s0_axi_wvalid && s0_axi_wready));
      if (len != 0) begin
         s0_axi_wdata <= second;
         s0_axi_wlast <= 1'b1;
         do @(posedge s0_axi_aclk); while (!(s0_axi_wvalid && s0_axi_wready));
      end
      s0_axi_wvalid <= 1'b0;
      s0_axi_wlast  <= 1'b0;
   endtask

   // OpenCAPI model takes the write command after a random gap
   task automatic take_wcmd(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                            input oc_data_t data);
      while (!oc_write_command_valid) @(posedge s0_axi_aclk);
      repeat ($random(seed) & 3) @(posedge s0_axi_aclk);
      oc_write_command_ready <= 1'b1;
      @(posedge s0_axi_aclk);
      oc_write_command_ready <= 1'b0;
      check_id("command id", id, oc_write_command_id);
      check_addr("command address", addr, oc_write_command_address);
      check_len("command length", len, oc_write_command_length);
      check_oc_data("command data", data, oc_write_command_data);
   endtask

   task automatic return_b(input axi_id_t id, input axi_resp_t resp);
      oc_trans_bid    <= id;
      oc_trans_bresp  <= resp;
      oc_trans_bvalid <= 1'b1;
      do @(posedge s0_axi_aclk); while (!(oc_trans_bvalid && oc_trans_bready));
      oc_trans_bvalid <= 1'b0;
   endtask

   task automatic take_b(input axi_id_t id, input axi_resp_t resp);
      logic done;
      done = 1'b0;
      while (!done) begin
         s0_axi_bready <= coin();
         @(posedge s0_axi_aclk);
         if (s0_axi_bvalid && s0_axi_bready) begin
            check_id("bid", id, s0_axi_bid);
            check_resp("bresp", resp, s0_axi_bresp);
            done = 1'b1;
         end
      end
      s0_axi_bready <= 1'b0;
      @(posedge s0_axi_aclk);
      if (s0_axi_bvalid) begin
         report_failure("B stayed valid after the response was taken");
      end
   endtask

   task automatic do_write(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                           input axi_data_t first, input axi_data_t second,
                           input axi_resp_t resp);
      drive_aw(id, addr, len);
      wait_aw();
      send_w(len, first, second);
      take_wcmd(id, addr, len, write_word(len, first, second));
      return_b(id, resp);
      take_b(id, resp);
   endtask

   task automatic take_rcmd(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
      while (!oc_read_command_valid) @(posedge s0_axi_aclk);
      repeat ($random(seed) & 3) @(posedge s0_axi_aclk);
      oc_read_command_ready <= 1'b1;
      @(posedge s0_axi_aclk);
      oc_read_command_ready <= 1'b0;
      check_id("read command id", id, oc_read_command_id);
      check_addr("read command address", addr, oc_read_command_address);
      check_len("read command length", len, oc_read_command_length);
   endtask

   task automatic take_r(input axi_id_t id, input axi_len_t len, input axi_data_t first,
                         input axi_data_t second, input axi_resp_t resp);
      int        n;
      int        beats;
      axi_data_t exp;
      n = 0;
      beats = (len == 0) ? 1 : 2;
      while (n < beats) begin
         s0_axi_rready <= coin();
         @(posedge s0_axi_aclk);
         if (s0_axi_rvalid && s0_axi_rready) begin
            // Two beats come out half 1 then half 0
            // A single beat is half 0
            exp = (beats == 2 && n == 0) ? first : second;
            check_id("rid", id, s0_axi_rid);
            check_beat("rdata", exp, s0_axi_rdata);
            check_resp("rresp", resp, s0_axi_rresp);
            check_last("rlast", n == beats - 1, s0_axi_rlast);
            n++;
         end
      end
      s0_axi_rready <= 1'b0;
      @(posedge s0_axi_aclk);
      if (s0_axi_rvalid) begin
         report_failure("R stayed valid after the last beat");
      end
   endtask

   task automatic run_read(input int i);
      oc_data_t word;
      word.beat[1] = t_first[i];
      word.beat[0] = t_second[i];
      s0_axi_arid    <= t_id[i];
      s0_axi_araddr  <= t_addr[i];
      s0_axi_arlen   <= t_len[i];
      s0_axi_arvalid <= 1'b1;
      do @(posedge s0_axi_aclk); while (!(s0_axi_arvalid && s0_axi_arready));
      s0_axi_arvalid <= 1'b0;
      take_rcmd(t_id[i], t_addr[i], t_len[i]);
      oc_trans_rid    <= t_id[i];
      oc_trans_rdata  <= word;
      oc_trans_rresp  <= t_resp[i];
      oc_trans_rvalid <= 1'b1;
      do @(posedge s0_axi_aclk); while (!(oc_trans_rvalid && oc_trans_rready));
      oc_trans_rvalid <= 1'b0;
      take_r(t_id[i], t_len[i], t_first[i], t_second[i], t_resp[i]);
   endtask

   task automatic run_busy(input int i);
      axi_id_t   other;
      axi_addr_t later_addr;
      oc_data_t  later_word;
      other = t_id[i] ^ 4'h1;
      later_addr = t_addr[i] + 64'h80;
      later_word = write_word(t_len[i], t_second[i], t_first[i]);
      // First write keeps its ID busy while its B is held back
      drive_aw(t_id[i], t_addr[i], t_len[i]);
      wait_aw();
      send_w(t_len[i], t_first[i], t_second[i]);
      take_wcmd(t_id[i], t_addr[i], t_len[i], write_word(t_len[i], t_first[i], t_second[i]));
      // Another ID gets through meanwhile
      do_write(other, t_addr[i] + 64'h40, t_len[i], t_second[i], t_first[i], t_resp[i]);
      drive_aw(t_id[i], later_addr, t_len[i]);
      repeat (8) begin
         @(posedge s0_axi_aclk);
         if (s0_axi_awready || oc_write_command_valid) begin
            report_failure("a write to a busy ID went ahead before the first B");
         end
      end
      return_b(t_id[i], t_resp[i]);
      take_b(t_id[i], t_resp[i]);
      wait_aw();
      send_w(t_len[i], t_second[i], t_first[i]);
      take_wcmd(t_id[i], later_addr, t_len[i], later_word);
      return_b(t_id[i], t_resp[i]);
      take_b(t_id[i], t_resp[i]);
   endtask

   task automatic build_table();
      add_test(kind_write, 4'h3, 64'h0000_0010_0000_0040, 8'd0, 32'hcafe_0001, 32'h0bad_0bad,
               2'b00, "write_one_beat");
      add_test(kind_write, 4'h5, 64'h0000_0020_0000_1000, 8'd1, 32'h1111_aaaa, 32'h2222_bbbb,
               2'b10, "write_two_beats");
      add_test(kind_read, 4'h3, 64'h0000_0030_0000_0080, 8'd0, 32'h3333_cccc, 32'h4444_dddd,
               2'b00, "read_one_beat");
      add_test(kind_read, 4'h9, 64'hffff_0000_0000_2000, 8'd1, 32'h5555_eeee, 32'h6666_ffff,
               2'b11, "read_two_beats");
      add_test(kind_busy, 4'h7, 64'h0000_0040_0000_0100, 8'd1, 32'h7777_0001, 32'h8888_0002,
               2'b01, "write_busy_id");
      // Random data for the back-pressure entries
      // Random ready gaps apply to every entry
      add_test(kind_write, 4'h2, 64'h0000_0050_0000_0200, 8'd1, $random(seed), $random(seed),
               2'b00, "backpressure_write");
      add_test(kind_read, 4'h2, 64'h0000_0060_0000_0300, 8'd1, $random(seed), $random(seed),
               2'b10, "backpressure_read");
      add_test(kind_read, 4'hc, 64'h0000_0070_0000_0400, 8'd0, $random(seed), $random(seed),
               2'b00, "backpressure_read_one");
   endtask

   task automatic init_inputs();
      rst_n                  = 1'b0;
      s0_axi_awid            = '0;
      s0_axi_awaddr          = '0;
      s0_axi_awlen           = '0;
      s0_axi_awvalid         = 1'b0;
      s0_axi_wdata           = '0;
      s0_axi_wlast           = 1'b0;
      s0_axi_wvalid          = 1'b0;
      s0_axi_bready          = 1'b0;
      s0_axi_arid            = '0;
      s0_axi_araddr          = '0;
      s0_axi_arlen           = '0;
      s0_axi_arvalid         = 1'b0;
      s0_axi_rready          = 1'b0;
      oc_write_command_ready = 1'b0;
      oc_trans_bvalid        = 1'b0;
      oc_trans_bid           = '0;
      oc_trans_bresp         = '0;
      oc_read_command_ready  = 1'b0;
      oc_trans_rvalid        = 1'b0;
      oc_trans_rid           = '0;
      oc_trans_rdata         = '0;
      oc_trans_rresp         = '0;
   endtask

   initial begin
      seed = 32'he864;
      errors = 0;
      passed = 0;
      failed = 0;
      init_inputs();
      build_table();
      repeat (2) @(posedge s0_axi_aclk);
      rst_n <= 1'b1;
      @(posedge s0_axi_aclk);
      for (int i = 0; i < t_kind.size(); i++) begin
         cur_name = t_name[i];
         test_ok = 1'b1;
         case (t_kind[i])
            kind_write: do_write(t_id[i], t_addr[i], t_len[i], t_first[i], t_second[i],
                                 t_resp[i]);
            kind_read:  run_read(i);
            default:    run_busy(i);
         endcase
         if (test_ok) begin
            passed++;
         end else begin
            failed++;
         end
         $display("test %-22s %s", cur_name, test_ok ? "ok" : "failed");
      end
      if (u_dut.u_assertions.fail_count != 0) begin
         $display("%0d bound assertions failed during the run",
                  u_dut.u_assertions.fail_count);
         errors += u_dut.u_assertions.fail_count;
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               t_kind.size(), passed, failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Run limit of 200 cycles per table entry
   initial begin : watchdog
      int limit;
      int cycles;
      cycles = 0;
      @(posedge s0_axi_aclk);
      limit = 200 * t_kind.size();
      while (cycles < limit) begin
         @(posedge s0_axi_aclk);
         cycles++;
      end
      $display("timeout after %0d cycles, the DUT stopped completing handshakes", limit);
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- compile.f
+incdir+include
src/axi_pkg.sv
src/ocx_pkg.sv
src/outstanding_id_table.sv
src/axi_write_channels.sv
src/axi_read_channels.sv
src/ocx_tlx_axi_bridge.sv
bench/bridge_assertions.sv
bench/bridge_tb.sv
